// ==== design/meter_pkg.sv ====
`default_nettype none

package meter_pkg;

  // ----------------------------------------------------------
  // Data types along the audio path
  // ----------------------------------------------------------

  // Signed PCM sample out of the decimator
  typedef logic signed [11:0] sample_t;

  // Absolute value of a sample
  typedef logic [11:0] magnitude_t;

  // Meter level, 0 to 10
  typedef logic [3:0] level_t;

  // PWM duty and PWM period counter
  typedef logic [7:0] duty_t;

  // ----------------------------------------------------------
  // Constants
  // ----------------------------------------------------------

  // Samples are clipped symmetrically to +/- this bound
  localparam int SAMPLE_MAX = 2047;

  // Top of the meter scale
  localparam level_t LEVEL_MAX = 4'd10;

  // Duty added for each level step
  localparam duty_t LEVEL_STEP = 8'd25;

  // Colour thresholds, highest green-only and highest amber level
  localparam level_t GREEN_TOP = 4'd4;
  localparam level_t AMBER_TOP = 4'd8;

endpackage

`default_nettype wire

// ==== design/pdm_decimator.sv ====
`default_nettype none

module pdm_decimator #(
  parameter int MIC_CLK_HALF = 6,
  parameter int DECIM_RATIO  = 64
) (
  input  wire logic          clk,
  input  wire logic          arst_n_i,
  input  wire logic          mic_data_i,
  output logic               mic_clk_o,
  output meter_pkg::sample_t sample_o,
  output logic               sample_valid_o
);

  localparam int DIV_W = (MIC_CLK_HALF > 1) ? $clog2(MIC_CLK_HALF) : 1;
  localparam int BIT_W = (DECIM_RATIO > 1) ? $clog2(DECIM_RATIO) : 1;
  localparam int ACC_W = BIT_W + 1;
  // Maps the ones count onto the full 12-bit range
  localparam int SCALE = 2048 / DECIM_RATIO;

  logic [DIV_W-1:0]   div_cnt;
  logic               div_wrap;
  logic               mic_rise;
  logic [BIT_W-1:0]   bit_cnt;
  logic               frame_last;
  logic [ACC_W-1:0]   ones_acc;
  logic [ACC_W-1:0]   ones_total;
  int                 scaled;
  meter_pkg::sample_t sample_next;

  // ----------------------------------------------------------
  // Microphone clock
  // ----------------------------------------------------------
  assign div_wrap = (div_cnt == DIV_W'(MIC_CLK_HALF - 1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_cnt   <= '0;
      mic_clk_o <= 1'b0;
      mic_rise  <= 1'b0;
    end else begin
      // High in the cycle where mic_clk_o has just gone high
      mic_rise <= div_wrap && !mic_clk_o;
      if (div_wrap) begin
        div_cnt   <= '0;
        mic_clk_o <= ~mic_clk_o;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Frame bit counter and ones accumulator
  // ----------------------------------------------------------
  assign frame_last = (bit_cnt == BIT_W'(DECIM_RATIO - 1));
  assign ones_total = ones_acc + ACC_W'(mic_data_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt  <= '0;
      ones_acc <= '0;
    end else if (mic_rise) begin
      if (frame_last) begin
        bit_cnt  <= '0;
        ones_acc <= '0;
      end else begin
        bit_cnt  <= bit_cnt + 1'b1;
        ones_acc <= ones_total;
      end
    end
  end

  // ----------------------------------------------------------
  // Scale to signed range and saturate
  // ----------------------------------------------------------
  always_comb begin
    scaled = (2 * int'(ones_total) - DECIM_RATIO) * SCALE;
    if (scaled > meter_pkg::SAMPLE_MAX) begin
      sample_next = meter_pkg::sample_t'(meter_pkg::SAMPLE_MAX);
    end else if (scaled < -meter_pkg::SAMPLE_MAX) begin
      sample_next = meter_pkg::sample_t'(-meter_pkg::SAMPLE_MAX);
    end else begin
      sample_next = meter_pkg::sample_t'(scaled);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= mic_rise && frame_last;
    end
  end

  always_ff @(posedge clk) begin
    if (mic_rise && frame_last) begin
      sample_o <= sample_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/volume_meter.sv ====
`default_nettype none

module volume_meter #(
  parameter int WINDOW_SAMPLES = 2000
) (
  input  wire logic                clk,
  input  wire logic                arst_n_i,
  input  wire meter_pkg::sample_t  sample_i,
  input  wire logic                sample_valid_i,
  output meter_pkg::level_t        level_o,
  output logic                     level_valid_o
);

  localparam int WIN_W = (WINDOW_SAMPLES > 1) ? $clog2(WINDOW_SAMPLES) : 1;

  meter_pkg::magnitude_t magnitude;
  meter_pkg::magnitude_t peak_q;
  meter_pkg::magnitude_t peak_next;
  logic [WIN_W-1:0]      win_cnt;
  logic                  win_last;

  // ----------------------------------------------------------
  // Leading-one ranking of the peak
  // ----------------------------------------------------------
  function automatic meter_pkg::level_t rank_peak(input meter_pkg::magnitude_t pk);
    meter_pkg::level_t lvl;
    if (pk[11] || pk[10]) begin
      lvl = meter_pkg::LEVEL_MAX;
    end else if (pk[9]) begin
      lvl = 4'd8;
    end else if (pk[8]) begin
      lvl = 4'd6;
    end else if (pk[7]) begin
      lvl = 4'd4;
    end else if (pk[6]) begin
      lvl = 4'd3;
    end else if (pk[5]) begin
      lvl = 4'd2;
    end else if (pk[4]) begin
      lvl = 4'd1;
    end else begin
      // Below bit 4 counts as silence
      lvl = 4'd0;
    end
    return lvl;
  endfunction

  // ----------------------------------------------------------
  // Magnitude and running peak
  // ----------------------------------------------------------

  // -2048 wraps to 12'h800, still correct as unsigned
  assign magnitude = (sample_i < 0) ? meter_pkg::magnitude_t'(-sample_i)
                                    : meter_pkg::magnitude_t'(sample_i);

  // Peak including the current sample
  assign peak_next = (magnitude > peak_q) ? magnitude : peak_q;

  assign win_last = (win_cnt == WIN_W'(WINDOW_SAMPLES - 1));

  // ----------------------------------------------------------
  // Window counter and level register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      peak_q        <= '0;
      win_cnt       <= '0;
      level_o       <= '0;
      level_valid_o <= 1'b0;
    end else begin
      level_valid_o <= 1'b0;
      if (sample_valid_i) begin
        if (win_last) begin
          level_o       <= rank_peak(peak_next);
          level_valid_o <= 1'b1;
          // Next window starts from silence
          peak_q        <= '0;
          win_cnt       <= '0;
        end else begin
          peak_q  <= peak_next;
          win_cnt <= win_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/status_led_pwm.sv ====
`default_nettype none

module status_led_pwm (
  input  wire logic               clk,
  input  wire logic               arst_n_i,
  input  wire meter_pkg::level_t  level_i,
  input  wire logic               level_valid_i,
  output logic                    stat_r_o,
  output logic                    stat_g_o
);

  meter_pkg::duty_t  pwm_cnt;
  logic              pwm_wrap;
  meter_pkg::level_t pending_level;
  meter_pkg::level_t active_level;
  meter_pkg::duty_t  duty;
  logic              red_en;
  logic              green_en;
  logic              pwm_on;

  // ----------------------------------------------------------
  // Free-running PWM counter
  // ----------------------------------------------------------
  assign pwm_wrap = (pwm_cnt == '1);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Level capture, applied only at period boundary
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_level <= '0;
      active_level  <= '0;
    end else begin
      if (level_valid_i) begin
        pending_level <= level_i;
      end
      // New level takes effect when the counter restarts at 0
      if (pwm_wrap) begin
        active_level <= pending_level;
      end
    end
  end

  // ----------------------------------------------------------
  // Colour and duty
  // ----------------------------------------------------------
  assign duty     = meter_pkg::duty_t'(active_level) * meter_pkg::LEVEL_STEP;
  assign red_en   = (active_level > meter_pkg::GREEN_TOP);
  assign green_en = (active_level != '0) && (active_level <= meter_pkg::AMBER_TOP);
  assign pwm_on   = (pwm_cnt < duty);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stat_r_o <= 1'b0;
      stat_g_o <= 1'b0;
    end else begin
      stat_r_o <= red_en && pwm_on;
      stat_g_o <= green_en && pwm_on;
    end
  end

endmodule

`default_nettype wire

// ==== design/audio_meter_top.sv ====
`default_nettype none

module audio_meter_top #(
  parameter int MIC_CLK_HALF   = 6,
  parameter int DECIM_RATIO    = 64,
  parameter int WINDOW_SAMPLES = 2000
) (
  input  wire logic          clk,
  input  wire logic          arst_n_i,
  input  wire logic          mic_data_i,
  output logic               mic_clk_o,
  output meter_pkg::level_t  level_o,
  output logic               level_valid_o,
  output logic               stat_r_o,
  output logic               stat_g_o
);

  meter_pkg::sample_t sample;
  logic               sample_valid;

  // ----------------------------------------------------------
  // PDM microphone front end
  // ----------------------------------------------------------
  pdm_decimator #(
    .MIC_CLK_HALF ( MIC_CLK_HALF ),
    .DECIM_RATIO  ( DECIM_RATIO  )
  ) i_pdm_decimator (
    .clk            ( clk          ),
    .arst_n_i       ( arst_n_i     ),
    .mic_data_i     ( mic_data_i   ),
    .mic_clk_o      ( mic_clk_o    ),
    .sample_o       ( sample       ),
    .sample_valid_o ( sample_valid )
  );

  // ----------------------------------------------------------
  // Peak meter
  // ----------------------------------------------------------
  volume_meter #(
    .WINDOW_SAMPLES ( WINDOW_SAMPLES )
  ) i_volume_meter (
    .clk            ( clk           ),
    .arst_n_i       ( arst_n_i      ),
    .sample_i       ( sample        ),
    .sample_valid_i ( sample_valid  ),
    .level_o        ( level_o       ),
    .level_valid_o  ( level_valid_o )
  );

  // ----------------------------------------------------------
  // Status LED drive, blue left unused
  // ----------------------------------------------------------
  status_led_pwm i_status_led_pwm (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .level_i       ( level_o       ),
    .level_valid_i ( level_valid_o ),
    .stat_r_o      ( stat_r_o      ),
    .stat_g_o      ( stat_g_o      )
  );

endmodule

`default_nettype wire

// ==== dv/audio_meter_checker.sv ====
`default_nettype none

module audio_meter_checker #(
  parameter int MIC_CLK_HALF  = 1,
  parameter int WINDOW_CYCLES = 512
) (
  input  wire logic       clk,
  input  wire logic       arst_n_i,
  input  wire logic       mic_clk_i,
  input  wire logic [3:0] level_i,
  input  wire logic       level_valid_i,
  input  wire logic       stat_r_i,
  input  wire logic       stat_g_i,
  input  wire logic [3:0] exp_level_i,
  input  wire logic       exp_red_i,
  input  wire logic       exp_green_i,
  output int              rows_done_o,
  output int              rows_passed_o,
  output int              errors_o
);

  localparam int DUTY_STEP  = 25;
  localparam int PWM_PERIOD = 256;

  int         pulse_cnt;
  int         cyc;
  int         last_pulse_cyc;
  int         since_level;
  int         red_high;
  int         green_high;
  int         row_errors;
  int         mic_hold;
  logic       mic_prev;
  logic       valid_prev;
  logic       measuring;
  logic [3:0] row_level;
  logic       row_red;
  logic       row_green;

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors_o   = errors_o + 1;
    row_errors = row_errors + 1;
  endtask

  task automatic check_led(input string name, input logic lit, input int high);
    if (!lit && high != 0) begin
      report_error($sformatf("%s LED high for %0d cycles, expected dark", name, high));
    end else if (lit && high != int'(row_level) * DUTY_STEP) begin
      report_error($sformatf("%s LED high for %0d cycles, expected %0d", name, high,
                             int'(row_level) * DUTY_STEP));
    end
  endtask

  task automatic finish_row();
    check_led("red", row_red, red_high);
    check_led("green", row_green, green_high);
    $display("Row %0d: level %0d, red %0d, green %0d cycles high: %s", rows_done_o,
             row_level, red_high, green_high, (row_errors == 0) ? "ok" : "failed");
    rows_done_o = rows_done_o + 1;
    if (row_errors == 0) begin
      rows_passed_o = rows_passed_o + 1;
    end
    row_errors = 0;
  endtask

  initial begin
    pulse_cnt      = 0;
    cyc            = 0;
    last_pulse_cyc = 0;
    since_level    = 0;
    red_high       = 0;
    green_high     = 0;
    row_errors     = 0;
    mic_hold       = 0;
    mic_prev       = 1'b0;
    valid_prev     = 1'b0;
    measuring      = 1'b0;
    row_level      = '0;
    row_red        = 1'b0;
    row_green      = 1'b0;
    rows_done_o    = 0;
    rows_passed_o  = 0;
    errors_o       = 0;
  end

  // ----------------------------------------------------------
  // Reset values, strobe spacing, level and duty
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!arst_n_i || (pulse_cnt == 0 && !level_valid_i)) begin
      if (level_valid_i !== 1'b0 || stat_r_i !== 1'b0 || stat_g_i !== 1'b0 ||
          level_i !== 4'd0) begin
        report_error("outputs not idle during reset or before the first level");
      end
    end
    // Microphone clock holds each level for MIC_CLK_HALF cycles
    if (!arst_n_i) begin
      mic_hold = 0;
      if (mic_clk_i !== 1'b0) begin
        report_error("mic_clk_o not low during reset");
      end
    end else if (mic_clk_i !== mic_prev) begin
      if (mic_hold != MIC_CLK_HALF) begin
        report_error($sformatf("mic_clk_o held %0d cycles, expected %0d", mic_hold,
                               MIC_CLK_HALF));
      end
      mic_hold = 1;
    end else begin
      mic_hold = mic_hold + 1;
      if (mic_hold == MIC_CLK_HALF + 1) begin
        report_error("mic_clk_o did not toggle in time");
      end
    end
    mic_prev = mic_clk_i;
    if (arst_n_i) begin
      // Duty is measured over one full PWM period, late in the window
      if (measuring) begin
        since_level = since_level + 1;
        if (since_level >= PWM_PERIOD) begin
          red_high   = red_high + int'(stat_r_i);
          green_high = green_high + int'(stat_g_i);
        end
        if (since_level == 2 * PWM_PERIOD - 1) begin
          finish_row();
          measuring = 1'b0;
        end
      end
      if (level_valid_i && valid_prev) begin
        report_error("level_valid_o high for more than one cycle");
      end
      if (level_valid_i && !valid_prev) begin
        if (pulse_cnt > 0 && cyc - last_pulse_cyc != WINDOW_CYCLES) begin
          report_error($sformatf("level strobes %0d cycles apart, expected %0d",
                                 cyc - last_pulse_cyc, WINDOW_CYCLES));
        end
        last_pulse_cyc = cyc;
        // Third window of a row
        if (pulse_cnt % 4 == 2) begin
          row_level = exp_level_i;
          row_red   = exp_red_i;
          row_green = exp_green_i;
          if (level_i !== exp_level_i) begin
            report_error($sformatf("level %0d, expected %0d", level_i, exp_level_i));
          end
          measuring   = 1'b1;
          since_level = 0;
          red_high    = 0;
          green_high  = 0;
        end
        pulse_cnt = pulse_cnt + 1;
      end
    end
    valid_prev = level_valid_i;
  end

endmodule

`default_nettype wire

// ==== dv/tb_audio_meter.sv ====
`default_nettype none

module tb_audio_meter;

  localparam int MIC_CLK_HALF    = 1;
  localparam int DECIM_RATIO     = 64;
  localparam int WINDOW_SAMPLES  = 4;
  localparam int FRAME_CYCLES    = 2 * MIC_CLK_HALF * DECIM_RATIO;
  localparam int WINDOW_CYCLES   = FRAME_CYCLES * WINDOW_SAMPLES;
  localparam int NUM_ROWS        = 7;
  localparam int WINDOWS_PER_ROW = 4;
  localparam int FRAMES_PER_ROW  = WINDOWS_PER_ROW * WINDOW_SAMPLES;
  localparam int TIMEOUT_CYCLES  = NUM_ROWS * WINDOWS_PER_ROW * WINDOW_CYCLES + 2000;
  localparam int DRIVE_DLY       = 1;
  localparam int SEED            = 90;

  logic       clk;
  logic       arst_n;
  logic       mic_data;
  logic       mic_clk;
  logic [3:0] level;
  logic       level_valid;
  logic       stat_r;
  logic       stat_g;
  logic [3:0] exp_level;
  logic       exp_red;
  logic       exp_green;
  int         rows_done;
  int         rows_passed;
  int         errors;

  // Stimulus table, ones per frame and expected result
  int         row_k     [NUM_ROWS];
  logic [3:0] row_level [NUM_ROWS];
  logic       row_red   [NUM_ROWS];
  logic       row_green [NUM_ROWS];
  logic       frame_bits [DECIM_RATIO];

  audio_meter_top #(
    .MIC_CLK_HALF   ( MIC_CLK_HALF   ),
    .DECIM_RATIO    ( DECIM_RATIO    ),
    .WINDOW_SAMPLES ( WINDOW_SAMPLES )
  ) i_dut (
    .clk           ( clk         ),
    .arst_n_i      ( arst_n      ),
    .mic_data_i    ( mic_data    ),
    .mic_clk_o     ( mic_clk     ),
    .level_o       ( level       ),
    .level_valid_o ( level_valid ),
    .stat_r_o      ( stat_r      ),
    .stat_g_o      ( stat_g      )
  );

  audio_meter_checker #(
    .MIC_CLK_HALF  ( MIC_CLK_HALF  ),
    .WINDOW_CYCLES ( WINDOW_CYCLES )
  ) i_checker (
    .clk           ( clk         ),
    .arst_n_i      ( arst_n      ),
    .mic_clk_i     ( mic_clk     ),
    .level_i       ( level       ),
    .level_valid_i ( level_valid ),
    .stat_r_i      ( stat_r      ),
    .stat_g_i      ( stat_g      ),
    .exp_level_i   ( exp_level   ),
    .exp_red_i     ( exp_red     ),
    .exp_green_i   ( exp_green   ),
    .rows_done_o   ( rows_done   ),
    .rows_passed_o ( rows_passed ),
    .errors_o      ( errors      )
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  // ----------------------------------------------------------
  // Table and PDM driver
  // ----------------------------------------------------------
  task automatic set_row(input int idx, input int k, input int lvl, input logic red,
                         input logic green);
    row_k[idx]     = k;
    row_level[idx] = 4'(lvl);
    row_red[idx]   = red;
    row_green[idx] = green;
  endtask

  task automatic load_table();
    set_row(0, 32, 0, 1'b0, 1'b0);
    set_row(1, 33, 3, 1'b0, 1'b1);
    set_row(2, 34, 4, 1'b0, 1'b1);
    set_row(3, 36, 6, 1'b1, 1'b1);
    set_row(4, 40, 8, 1'b1, 1'b1);
    // Both ends clip to full scale
    set_row(5, 64, 10, 1'b1, 1'b0);
    set_row(6, 0, 10, 1'b1, 1'b0);
  endtask

  // K ones at random positions within a frame
  task automatic shuffle_frame(input int k);
    int   i;
    int   j;
    logic tmp;
    for (i = 0; i < DECIM_RATIO; i++) begin
      frame_bits[i] = (i < k);
    end
    for (i = DECIM_RATIO - 1; i > 0; i--) begin
      j             = $urandom % (i + 1);
      tmp           = frame_bits[i];
      frame_bits[i] = frame_bits[j];
      frame_bits[j] = tmp;
    end
  endtask

  // Returns just after the clk edge at which mic_clk rose
  task automatic wait_mic_rise();
    logic prev;
    prev = mic_clk;
    @(posedge clk);
    #DRIVE_DLY;
    while (!(mic_clk && !prev)) begin
      prev = mic_clk;
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  task automatic drive_rows();
    int r;
    int f;
    int b;
    for (r = 0; r < NUM_ROWS; r++) begin
      exp_level = row_level[r];
      exp_red   = row_red[r];
      exp_green = row_green[r];
      for (f = 0; f < FRAMES_PER_ROW; f++) begin
        shuffle_frame(row_k[r]);
        for (b = 0; b < DECIM_RATIO; b++) begin
          wait_mic_rise();
          mic_data = frame_bits[b];
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    arst_n    = 1'b0;
    mic_data  = 1'b0;
    exp_level = '0;
    exp_red   = 1'b0;
    exp_green = 1'b0;
    void'($urandom(SEED));
    load_table();
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    drive_rows();
    wait (rows_done == NUM_ROWS);
    @(posedge clk);
    #DRIVE_DLY;
    $display("Rows checked: %0d, passed: %0d, errors: %0d", rows_done, rows_passed, errors);
    if (errors == 0 && rows_passed == NUM_ROWS) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== audio_meter.f ====
design/meter_pkg.sv
design/pdm_decimator.sv
design/volume_meter.sv
design/status_led_pwm.sv
design/audio_meter_top.sv
dv/audio_meter_checker.sv
dv/tb_audio_meter.sv
